// File: hdl/qrd_num_pkg.sv
package qrd_num_pkg;

    // matrix entries and CORDIC coordinates
    localparam int DATA_W = 14;
    typedef logic signed [DATA_W-1:0] data_t;

    // angles in radians, sign plus three integer bits
    localparam int ANGLE_FRAC = 10;
    typedef logic signed [ANGLE_FRAC+3:0] angle_t;

    // gain correction is a pure fraction below one
    localparam int GAIN_FRAC = 10;
    typedef logic [GAIN_FRAC-1:0] gain_t;

    localparam int ITER_W = 4;
    typedef logic [ITER_W-1:0] iter_t;

    // atan(2^-i) scaled by 2^ANGLE_FRAC
    localparam angle_t ATAN_TABLE [0:12] = '{
        14'sd804, 14'sd475, 14'sd251, 14'sd127,
        14'sd64,  14'sd32,  14'sd16,  14'sd8,
        14'sd4,   14'sd2,   14'sd1,   14'sd0,
        14'sd0
    };

    // 1/K after n applied micro-rotations, index is the rotation count
    // counts from 5 upward have settled to the limit 0.6073
    localparam gain_t GAIN_TABLE [1:13] = '{
        10'd724, 10'd648, 10'd628, 10'd623,
        10'd622, 10'd622, 10'd622, 10'd622,
        10'd622, 10'd622, 10'd622, 10'd622,
        10'd622
    };

endpackage

// File: hdl/qrd_ctrl_pkg.sv
package qrd_ctrl_pkg;

    // micro-rotations per CORDIC pass
    localparam int NUM_ITER = 13;
    localparam int LAST_ITER = NUM_ITER - 1;

    // one load cycle ahead of the iterations
    localparam int PHASE_LEN = NUM_ITER + 1;

    // IDLE      waiting for an input request
    // VECTOR    vectoring pass on (a, c)
    // ROTATE    rotation pass on (b, d)
    // ACK_IN    results ready, input handshake still open
    // OUT_REQ   results offered to the sink
    // OUT_WAIT  waiting for the sink to drop its ack
    typedef enum logic [2:0] {
        IDLE     = 3'd0,
        ACK_IN   = 3'd1,
        VECTOR   = 3'd2,
        ROTATE   = 3'd3,
        OUT_REQ  = 3'd4,
        OUT_WAIT = 3'd5
    } seq_state_t;

endpackage

// File: hdl/cordic_core.sv
module cordic_core #(
    parameter int VECTORING = 1
) (
    input  logic                clk,
    input  logic                rst_n,
    input  logic                load_i,
    input  qrd_num_pkg::iter_t  iter_i,
    input  qrd_num_pkg::data_t  x_i,
    input  qrd_num_pkg::data_t  y_i,
    input  qrd_num_pkg::angle_t z_i,
    output qrd_num_pkg::data_t  x_o,
    output qrd_num_pkg::data_t  y_o,
    output qrd_num_pkg::angle_t z_o
);

    localparam int PROD_W = qrd_num_pkg::DATA_W + qrd_num_pkg::GAIN_FRAC + 1;
    localparam logic signed [PROD_W-1:0] HALF_LSB = 1 <<< (qrd_num_pkg::GAIN_FRAC - 1);

    qrd_num_pkg::data_t  x_q;
    qrd_num_pkg::data_t  y_q;
    qrd_num_pkg::angle_t z_q;
    qrd_num_pkg::iter_t  rot_cnt_q;
    logic                done_q;

    qrd_num_pkg::data_t  x_sft;
    qrd_num_pkg::data_t  y_sft;
    qrd_num_pkg::angle_t dz;
    logic                clockwise;
    logic                skip;
    logic                step;

    qrd_num_pkg::gain_t       gain;
    logic signed [PROD_W-1:0] x_prod;
    logic signed [PROD_W-1:0] y_prod;

    // shift stage, arithmetic so negative coordinates keep their sign
    assign x_sft = x_q >>> iter_i;
    assign y_sft = y_q >>> iter_i;
    assign dz    = qrd_num_pkg::ATAN_TABLE[iter_i];

    // vectoring drives y to zero, rotation drives z to zero
    generate
        if (VECTORING != 0) begin : g_vec
            assign clockwise = (y_q > 0);
            assign skip      = (y_q == '0);
        end else begin : g_rot
            assign clockwise = (z_q < 0);
            assign skip      = (z_q == '0);
        end
    endgenerate

    assign step = !load_i && !done_q && !skip;

    always_ff @(posedge clk) begin
        if (load_i) begin
            x_q <= x_i;
            y_q <= y_i;
            z_q <= z_i;
        end else if (step) begin
            if (clockwise) begin
                x_q <= x_q + y_sft;
                y_q <= y_q - x_sft;
                z_q <= z_q + dz;
            end else begin
                x_q <= x_q - y_sft;
                y_q <= y_q + x_sft;
                z_q <= z_q - dz;
            end
        end
    end

    // count applied rotations, freeze after the last iteration
    always_ff @(posedge clk) begin
        if (!rst_n) begin
            rot_cnt_q <= '0;
            done_q    <= 1'b1;
        end else if (load_i) begin
            rot_cnt_q <= '0;
            done_q    <= 1'b0;
        end else if (!done_q) begin
            if (!skip) begin
                rot_cnt_q <= rot_cnt_q + 1'b1;
            end
            if (iter_i == qrd_ctrl_pkg::LAST_ITER) begin
                done_q <= 1'b1;
            end
        end
    end

    always_comb begin
        gain = '0;
        if (rot_cnt_q != '0) begin
            gain = qrd_num_pkg::GAIN_TABLE[rot_cnt_q];
        end
    end

    // gain compensation, rounded to nearest
    assign x_prod = x_q * $signed({1'b0, gain}) + HALF_LSB;
    assign y_prod = y_q * $signed({1'b0, gain}) + HALF_LSB;

    assign x_o = (rot_cnt_q == '0) ? x_q
                                   : x_prod[qrd_num_pkg::GAIN_FRAC +: qrd_num_pkg::DATA_W];
    assign y_o = (rot_cnt_q == '0) ? y_q
                                   : y_prod[qrd_num_pkg::GAIN_FRAC +: qrd_num_pkg::DATA_W];
    assign z_o = z_q;

    // the sequencer keeps the iteration index inside the atan table
    a_iter_range: assert property (
        @(posedge clk) disable iff (!rst_n)
        !load_i |-> iter_i <= qrd_ctrl_pkg::LAST_ITER
    );

endmodule

// File: hdl/qrd_seq.sv
module qrd_seq (
    input  logic               clk,
    input  logic               rst_n,
    input  logic               in_req_i,
    input  logic               out_ack_i,
    output logic               in_ack_o,
    output logic               out_req_o,
    output logic               cap_o,
    output logic               vec_load_o,
    output logic               rot_load_o,
    output logic               ang_cap_o,
    output qrd_num_pkg::iter_t iter_o
);

    qrd_ctrl_pkg::seq_state_t state_q;
    qrd_ctrl_pkg::seq_state_t state_d;
    qrd_num_pkg::iter_t       cnt_q;
    qrd_num_pkg::iter_t       cnt_d;
    logic                     in_ack_q;
    logic                     phase_end;
    logic                     ack_open;

    assign phase_end = (cnt_q == qrd_num_pkg::iter_t'(qrd_ctrl_pkg::PHASE_LEN - 1));

    // input ack stays up past this edge only while the source still requests
    assign ack_open = in_ack_q && in_req_i;

    always_comb begin
        state_d = state_q;
        cnt_d   = cnt_q;
        case (state_q)
            qrd_ctrl_pkg::IDLE: begin
                if (in_req_i) begin
                    state_d = qrd_ctrl_pkg::VECTOR;
                    cnt_d   = '0;
                end
            end
            qrd_ctrl_pkg::VECTOR: begin
                if (phase_end) begin
                    state_d = qrd_ctrl_pkg::ROTATE;
                    cnt_d   = '0;
                end else begin
                    cnt_d = cnt_q + 1'b1;
                end
            end
            qrd_ctrl_pkg::ROTATE: begin
                if (phase_end) begin
                    state_d = ack_open ? qrd_ctrl_pkg::ACK_IN : qrd_ctrl_pkg::OUT_REQ;
                    cnt_d   = '0;
                end else begin
                    cnt_d = cnt_q + 1'b1;
                end
            end
            qrd_ctrl_pkg::ACK_IN: begin
                if (!ack_open) begin
                    state_d = qrd_ctrl_pkg::OUT_REQ;
                end
            end
            qrd_ctrl_pkg::OUT_REQ: begin
                if (out_ack_i) begin
                    state_d = qrd_ctrl_pkg::OUT_WAIT;
                end
            end
            qrd_ctrl_pkg::OUT_WAIT: begin
                if (!out_ack_i) begin
                    state_d = qrd_ctrl_pkg::IDLE;
                end
            end
            default: begin
                state_d = qrd_ctrl_pkg::IDLE;
                cnt_d   = '0;
            end
        endcase
    end

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            state_q <= qrd_ctrl_pkg::IDLE;
            cnt_q   <= '0;
        end else begin
            state_q <= state_d;
            cnt_q   <= cnt_d;
        end
    end

    // four-phase ack on the input side runs alongside the computation
    always_ff @(posedge clk) begin
        if (!rst_n) begin
            in_ack_q <= 1'b0;
        end else if (cap_o) begin
            in_ack_q <= 1'b1;
        end else if (!in_req_i) begin
            in_ack_q <= 1'b0;
        end
    end

    assign cap_o      = (state_q == qrd_ctrl_pkg::IDLE) && in_req_i;
    assign vec_load_o = (state_q == qrd_ctrl_pkg::VECTOR) && (cnt_q == '0);
    assign rot_load_o = (state_q == qrd_ctrl_pkg::ROTATE) && (cnt_q == '0);

    // count 0 is the load cycle and each later count is one iteration
    assign iter_o = (cnt_q == '0) ? '0 : cnt_q - 1'b1;

    assign ang_cap_o = (state_q == qrd_ctrl_pkg::VECTOR) &&
                       (iter_o == qrd_ctrl_pkg::LAST_ITER);

    assign in_ack_o  = in_ack_q;
    assign out_req_o = (state_q == qrd_ctrl_pkg::OUT_REQ);

    a_hs_excl: assert property (
        @(posedge clk) disable iff (!rst_n)
        !(out_req_o && in_ack_o)
    );

    a_req_hold: assert property (
        @(posedge clk) disable iff (!rst_n)
        out_req_o && !out_ack_i |=> out_req_o
    );

endmodule

// File: hdl/qrd_top.sv
module qrd_top (
    input  logic               clk,
    input  logic               rst_n,
    input  logic               in_req_i,
    input  logic               out_ack_i,
    input  qrd_num_pkg::data_t a_i,
    input  qrd_num_pkg::data_t b_i,
    input  qrd_num_pkg::data_t c_i,
    input  qrd_num_pkg::data_t d_i,
    output logic               in_ack_o,
    output logic               out_req_o,
    output qrd_num_pkg::data_t r11_o,
    output qrd_num_pkg::data_t r12_o,
    output qrd_num_pkg::data_t r22_o
);

    logic               cap;
    logic               vec_load;
    logic               rot_load;
    logic               ang_cap;
    qrd_num_pkg::iter_t iter;

    qrd_num_pkg::data_t  a_q;
    qrd_num_pkg::data_t  b_q;
    qrd_num_pkg::data_t  c_q;
    qrd_num_pkg::data_t  d_q;
    qrd_num_pkg::angle_t ang_q;
    qrd_num_pkg::angle_t vec_z;

    qrd_seq u_seq (
        .clk        (clk),
        .rst_n      (rst_n),
        .in_req_i   (in_req_i),
        .out_ack_i  (out_ack_i),
        .in_ack_o   (in_ack_o),
        .out_req_o  (out_req_o),
        .cap_o      (cap),
        .vec_load_o (vec_load),
        .rot_load_o (rot_load),
        .ang_cap_o  (ang_cap),
        .iter_o     (iter)
    );

    // matrix held for the whole transaction
    always_ff @(posedge clk) begin
        if (cap) begin
            a_q <= a_i;
            b_q <= b_i;
            c_q <= c_i;
            d_q <= d_i;
        end
    end

    // vectoring accumulates +theta, rotation needs -theta
    always_ff @(posedge clk) begin
        if (ang_cap) begin
            ang_q <= -vec_z;
        end
    end

    // first column, (a, c) -> (r11, 0)
    cordic_core #(
        .VECTORING (1)
    ) u_vec (
        .clk    (clk),
        .rst_n  (rst_n),
        .load_i (vec_load),
        .iter_i (iter),
        .x_i    (a_q),
        .y_i    (c_q),
        .z_i    ('0),
        .x_o    (r11_o),
        .y_o    (),
        .z_o    (vec_z)
    );

    // second column rotated by the same angle
    cordic_core #(
        .VECTORING (0)
    ) u_rot (
        .clk    (clk),
        .rst_n  (rst_n),
        .load_i (rot_load),
        .iter_i (iter),
        .x_i    (b_q),
        .y_i    (d_q),
        .z_i    (ang_q),
        .x_o    (r12_o),
        .y_o    (r22_o),
        .z_o    ()
    );

    // vectoring range only covers a right half-plane start
    a_a_nonneg: assert property (
        @(posedge clk) disable iff (!rst_n)
        cap |=> !a_q[qrd_num_pkg::DATA_W-1]
    );

endmodule

// File: testbench/tb_qrd_top.sv
module tb_qrd_top;

    timeunit 1ns;
    timeprecision 1ps;

    localparam int WAIT_LIMIT = 200;
    localparam int HS_LATENCY = 28;

    logic clk;
    logic rst_n;
    logic in_req;
    logic out_ack;
    qrd_num_pkg::data_t mat_a;
    qrd_num_pkg::data_t mat_b;
    qrd_num_pkg::data_t mat_c;
    qrd_num_pkg::data_t mat_d;
    logic in_ack;
    logic out_req;
    qrd_num_pkg::data_t r11;
    qrd_num_pkg::data_t r12;
    qrd_num_pkg::data_t r22;

    int errors;
    int timeouts;
    bit hung;
    int cyc = 0;
    int cap_cyc;
    logic [31:0] seed;

    qrd_top i_dut (
        .clk       (clk),
        .rst_n     (rst_n),
        .in_req_i  (in_req),
        .out_ack_i (out_ack),
        .a_i       (mat_a),
        .b_i       (mat_b),
        .c_i       (mat_c),
        .d_i       (mat_d),
        .in_ack_o  (in_ack),
        .out_req_o (out_req),
        .r11_o     (r11),
        .r12_o     (r12),
        .r22_o     (r22)
    );

    initial begin
        clk = 1'b0;
        forever #5 clk = ~clk;
    end

    // cycle index sampled on falling edges only
    always @(posedge clk) begin
        cyc <= cyc + 1;
    end

    function automatic logic [31:0] lcg_next(input logic [31:0] s);
        return s * 32'd1664525 + 32'd1013904223;
    endfunction

    function automatic int round_int(input real x);
        if (x >= 0.0) begin
            return $rtoi(x + 0.5);
        end
        return -$rtoi(-x + 0.5);
    endfunction

    task automatic check_val(input string name, input logic signed [31:0] actual,
                             input int expected, input int tol);
        int diff;
        diff = actual - expected;
        if (diff < 0) begin
            diff = -diff;
        end
        if (!hung && ($isunknown(actual) || diff > tol)) begin
            $display("ERR %s: got 0x%h expected 0x%h", name, actual, expected);
            errors++;
        end
    endtask

    // sel_out selects out_req_o instead of in_ack_o
    task automatic wait_for_level(input string what, input bit sel_out, input logic level,
                                  output int waited);
        logic seen;
        waited = 0;
        seen = sel_out ? out_req : in_ack;
        while (!hung && seen !== level) begin
            @(negedge clk);
            waited++;
            seen = sel_out ? out_req : in_ack;
            if (waited >= WAIT_LIMIT && seen !== level) begin
                $display("timeout while waiting for %s", what);
                timeouts++;
                hung = 1'b1;
            end
        end
    endtask

    task automatic send_matrix(input int a, input int b, input int c, input int d,
                               output int ack_wait);
        int n;
        @(negedge clk);
        mat_a = a;
        mat_b = b;
        mat_c = c;
        mat_d = d;
        in_req = 1'b1;
        wait_for_level("in_ack_o high", 1'b0, 1'b1, ack_wait);
        cap_cyc = cyc;
        in_req = 1'b0;
        wait_for_level("in_ack_o low", 1'b0, 1'b0, n);
    endtask

    task automatic collect_result(output int latency);
        int n;
        wait_for_level("out_req_o high", 1'b1, 1'b1, n);
        latency = cyc - cap_cyc;
    endtask

    task automatic release_output();
        int n;
        @(negedge clk);
        out_ack = 1'b1;
        wait_for_level("out_req_o low", 1'b1, 1'b0, n);
        out_ack = 1'b0;
    endtask

    // expected values from the Givens rotation in real arithmetic
    task automatic check_result(input int a, input int b, input int c, input int d,
                                input int tol_r11, input int tol_r2);
        real r;
        real e12;
        real e22;
        r = $sqrt(real'(a * a + c * c));
        if (r == 0.0) begin
            e12 = b;
            e22 = d;
        end else begin
            e12 = real'(a * b + c * d) / r;
            e22 = real'(a * d - c * b) / r;
        end
        check_val("r11_o", r11, round_int(r), tol_r11);
        check_val("r12_o", r12, round_int(e12), tol_r2);
        check_val("r22_o", r22, round_int(e22), tol_r2);
    endtask

    task automatic run_matrix(input int a, input int b, input int c, input int d,
                              input int tol_r11, input int tol_r2);
        int ack_wait;
        int lat;
        send_matrix(a, b, c, d, ack_wait);
        check_val("in_ack_o delay", ack_wait, 1, 0);
        collect_result(lat);
        check_val("out_req_o latency", lat, HS_LATENCY, 0);
        check_result(a, b, c, d, tol_r11, tol_r2);
        release_output();
    endtask

    task automatic test_reset();
        repeat (3) begin
            @(negedge clk);
            check_val("in_ack_o", in_ack, 0, 0);
            check_val("out_req_o", out_req, 0, 0);
        end
    endtask

    // c = 0 leaves both CORDICs untouched
    task automatic test_zero_c();
        run_matrix(1234, -567, 0, 890, 0, 0);
        run_matrix(0, 2047, 0, -2047, 0, 0);
        run_matrix(2047, -1, 0, 1, 0, 0);
    endtask

    task automatic test_vectoring();
        run_matrix(1000, 0, 500, 0, 4, 6);
        run_matrix(0, 0, 1500, 0, 4, 6);
        run_matrix(2047, 0, -2047, 0, 4, 6);
        run_matrix(300, 0, -1200, 0, 4, 6);
        run_matrix(1, 0, 1, 0, 4, 6);
    endtask

    task automatic test_rotation();
        run_matrix(1000, 800, 500, -600, 4, 6);
        run_matrix(120, -2047, 1900, 2047, 4, 6);
        run_matrix(2047, 1500, 2047, -1500, 4, 6);
        run_matrix(64, 333, -77, -444, 4, 6);
    endtask

    task automatic test_backpressure();
        int ack_wait;
        int lat;
        int n;
        int hold11;
        int hold12;
        int hold22;
        send_matrix(700, -300, 900, 1100, ack_wait);
        check_val("in_ack_o delay", ack_wait, 1, 0);
        collect_result(lat);
        check_val("out_req_o latency", lat, HS_LATENCY, 0);
        check_result(700, -300, 900, 1100, 4, 6);
        hold11 = r11;
        hold12 = r12;
        hold22 = r22;
        // second request raised while the sink stalls
        @(negedge clk);
        mat_a = 1500;
        mat_b = -800;
        mat_c = -400;
        mat_d = 250;
        in_req = 1'b1;
        repeat (20) begin
            @(negedge clk);
            check_val("out_req_o", out_req, 1, 0);
            check_val("in_ack_o", in_ack, 0, 0);
            check_val("r11_o", r11, hold11, 0);
            check_val("r12_o", r12, hold12, 0);
            check_val("r22_o", r22, hold22, 0);
        end
        out_ack = 1'b1;
        wait_for_level("out_req_o low", 1'b1, 1'b0, n);
        check_val("in_ack_o", in_ack, 0, 0);
        out_ack = 1'b0;
        wait_for_level("in_ack_o high", 1'b0, 1'b1, n);
        cap_cyc = cyc;
        repeat (3) begin
            @(negedge clk);
            check_val("in_ack_o", in_ack, 1, 0);
        end
        in_req = 1'b0;
        wait_for_level("in_ack_o low", 1'b0, 1'b0, n);
        collect_result(lat);
        check_val("out_req_o latency", lat, HS_LATENCY, 0);
        check_result(1500, -800, -400, 250, 4, 6);
        release_output();
    endtask

    task automatic test_random();
        int a;
        int b;
        int c;
        int d;
        repeat (8) begin
            seed = lcg_next(seed);
            a = int'(seed[26:16]);
            seed = lcg_next(seed);
            b = int'(seed[27:16] % 4095) - 2047;
            seed = lcg_next(seed);
            c = int'(seed[27:16] % 4095) - 2047;
            seed = lcg_next(seed);
            d = int'(seed[27:16] % 4095) - 2047;
            run_matrix(a, b, c, d, 4, 6);
        end
    endtask

    initial begin
        errors = 0;
        timeouts = 0;
        hung = 1'b0;
        cap_cyc = 0;
        seed = 32'h3d9c4417;
        rst_n = 1'b0;
        in_req = 1'b0;
        out_ack = 1'b0;
        mat_a = '0;
        mat_b = '0;
        mat_c = '0;
        mat_d = '0;
        repeat (5) @(posedge clk);
        @(negedge clk);
        rst_n = 1'b1;

        test_reset();
        test_zero_c();
        test_vectoring();
        test_rotation();
        test_backpressure();
        test_random();

        $display("errors: %0d  timeouts: %0d", errors, timeouts);
        if (errors == 0 && timeouts == 0) begin
            $display("test passed");
        end else begin
            $display("test failed");
        end
        $finish;
    end

endmodule

// File: qrd_top.f
hdl/qrd_num_pkg.sv
hdl/qrd_ctrl_pkg.sv
hdl/cordic_core.sv
hdl/qrd_seq.sv
hdl/qrd_top.sv
testbench/tb_qrd_top.sv

// File: Bender.yml
package:
  name: qrd_top

sources:
  - files:
      - hdl/qrd_num_pkg.sv
      - hdl/qrd_ctrl_pkg.sv
      - hdl/cordic_core.sv
      - hdl/qrd_seq.sv
      - hdl/qrd_top.sv
  - target: test
    files:
      - testbench/tb_qrd_top.sv
